/* Makefile */
# Verilator build and run of the MEM stage testbench.

SOURCES = common/mem_consts.svh common/CpuPkg.sv common/CachePkg.sv \
          hw/StoreAlign.sv dcache/DcacheDataRam.sv hw/DcacheRdataSel.sv \
          hw/MemStage.sv bench/MemStage_tb.sv

.PHONY: all run clean

all: run

obj_dir/VMemStage_tb: $(SOURCES) MemStage.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module MemStage_tb -f MemStage.f -o VMemStage_tb

run: obj_dir/VMemStage_tb
	./obj_dir/VMemStage_tb > sim.log 2>&1 || true
	cat sim.log
	grep -qx "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* MemStage.f */
+incdir+common
common/CpuPkg.sv
common/CachePkg.sv
hw/StoreAlign.sv
dcache/DcacheDataRam.sv
hw/DcacheRdataSel.sv
hw/MemStage.sv
bench/MemStage_tb.sv

/* bench/MemStage_tb.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module MemStage_tb;
    import CpuPkg::*;

    localparam int clkPeriod      = 10;
    localparam int resetCycles    = 16;
    localparam int ramBytes       = `DCACHE_WORDS * 4;
    localparam int byteBits       = $clog2(ramBytes);
    localparam int requestTotal   = 330;  // requests and stall cycles of all six tests.
    localparam int watchdogCycles = resetCycles + requestTotal * 4 + 200;

    localparam int opLb  = 0;
    localparam int opLbu = 1;
    localparam int opLh  = 2;
    localparam int opLhu = 3;
    localparam int opLw  = 4;
    localparam int opLwl = 5;
    localparam int opLwr = 6;
    localparam int opSb  = 7;
    localparam int opSh  = 8;
    localparam int opSw  = 9;
    localparam int opSwl = 10;
    localparam int opSwr = 11;

    logic      clk;
    logic      arstN;
    logic      stall;
    MemReq_t   memReq;
    WbResult_t wbResult;
    MemExc_t   memExc;

    logic [7:0] modelMem [ramBytes];  // byte-wide copy of the data ram, little endian.
    int         errorCount;
    int         checkCount;

    MemStage MemStage_i (
        .clk      (clk),
        .arstN    (arstN),
        .stall    (stall),
        .memReq   (memReq),
        .wbResult (wbResult),
        .memExc   (memExc)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [byteBits-1:0] byteIndex(input logic [31:0] addr);
        return addr[byteBits-1:0];  // addresses wrap with the ram size.
    endfunction

    function automatic logic [31:0] fillPattern(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic MemReq_t makeReq(input int op, input logic [31:0] addr,
                                        input logic [31:0] rt, input logic [4:0] dest);
        MemReq_t r;
        r         = '0;
        r.valid   = 1'b1;
        r.isLoad  = op <= opLwr;
        r.isStore = op >= opSb;
        r.addr    = addr;
        r.regRt   = rt;
        r.destReg = dest;
        case (op)
            opLb:    r.loadType  = LoadType_t'({`LOADTYPE_LB, `LR_NONE});
            opLbu:   r.loadType  = LoadType_t'({`LOADTYPE_LBU, `LR_NONE});
            opLh:    r.loadType  = LoadType_t'({`LOADTYPE_LH, `LR_NONE});
            opLhu:   r.loadType  = LoadType_t'({`LOADTYPE_LHU, `LR_NONE});
            opLw:    r.loadType  = LoadType_t'({`LOADTYPE_LW, `LR_NONE});
            opLwl:   r.loadType  = LoadType_t'({`LOADTYPE_LW, `LR_LEFT});
            opLwr:   r.loadType  = LoadType_t'({`LOADTYPE_LW, `LR_RIGHT});
            opSb:    r.storeType = StoreType_t'({`STORETYPE_SB, `LR_NONE});
            opSh:    r.storeType = StoreType_t'({`STORETYPE_SH, `LR_NONE});
            opSw:    r.storeType = StoreType_t'({`STORETYPE_SW, `LR_NONE});
            opSwl:   r.storeType = StoreType_t'({`STORETYPE_SW, `LR_LEFT});
            opSwr:   r.storeType = StoreType_t'({`STORETYPE_SW, `LR_RIGHT});
            default: r.valid     = 1'b0;
        endcase
        return r;
    endfunction

    // Halfword accesses need bit 0 clear, word accesses both low bits clear.
    function automatic logic misaligned(input MemReq_t r);
        logic [2:0] code;
        code = {r.loadType.sign, r.loadType.size};
        if (r.isLoad && r.loadType.leftOrRight == `LR_NONE) begin
            if (code == `LOADTYPE_LH || code == `LOADTYPE_LHU) begin
                return r.addr[0];
            end
            if (code == `LOADTYPE_LW) begin
                return |r.addr[1:0];
            end
        end
        if (r.isStore && r.storeType.leftOrRight == `LR_NONE) begin
            if (r.storeType.size == `STORETYPE_SH) begin
                return r.addr[0];
            end
            if (r.storeType.size == `STORETYPE_SW) begin
                return |r.addr[1:0];
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] loadValue(input MemReq_t r);
        logic [31:0] base;
        logic [31:0] word;
        logic [31:0] res;
        logic [7:0]  lane;
        logic [15:0] half;
        int          k;
        base = {r.addr[31:2], 2'b00};
        k    = int'(r.addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = modelMem[byteIndex(base + 32'(i))];
        end
        lane = word[8*k +: 8];
        half = r.addr[1] ? word[31:16] : word[15:0];
        res  = r.regRt;
        if (r.loadType.leftOrRight == `LR_LEFT) begin
            for (int i = 0; i <= k; i++) begin
                res[8*(3-k+i) +: 8] = word[8*i +: 8];  // low ram bytes go to the top.
            end
        end else if (r.loadType.leftOrRight == `LR_RIGHT) begin
            for (int i = k; i < 4; i++) begin
                res[8*(i-k) +: 8] = word[8*i +: 8];
            end
        end else begin
            case ({r.loadType.sign, r.loadType.size})
                `LOADTYPE_LB:  res = {{24{lane[7]}}, lane};
                `LOADTYPE_LBU: res = {24'h0, lane};
                `LOADTYPE_LH:  res = {{16{half[15]}}, half};
                `LOADTYPE_LHU: res = {16'h0, half};
                `LOADTYPE_LW:  res = word;
                default:       res = 'x;
            endcase
        end
        return res;
    endfunction

    task automatic applyStore(input MemReq_t r);
        logic [31:0] base;
        int          k;
        base = {r.addr[31:2], 2'b00};
        k    = int'(r.addr[1:0]);
        if (r.storeType.leftOrRight == `LR_LEFT) begin
            for (int i = 0; i <= k; i++) begin
                modelMem[byteIndex(base + 32'(i))] = r.regRt[8*(3-k+i) +: 8];
            end
        end else if (r.storeType.leftOrRight == `LR_RIGHT) begin
            for (int i = k; i < 4; i++) begin
                modelMem[byteIndex(base + 32'(i))] = r.regRt[8*(i-k) +: 8];
            end
        end else if (r.storeType.size == `STORETYPE_SB) begin
            modelMem[byteIndex(r.addr)] = r.regRt[7:0];
        end else if (r.storeType.size == `STORETYPE_SH) begin
            modelMem[byteIndex(r.addr)]         = r.regRt[7:0];
            modelMem[byteIndex(r.addr + 32'd1)] = r.regRt[15:8];
        end else begin
            for (int i = 0; i < 4; i++) begin
                modelMem[byteIndex(base + 32'(i))] = r.regRt[8*i +: 8];
            end
        end
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expV,
                                  input logic [31:0] actV);
        errorCount++;
        $display("error at %0t: %s expected %h got %h", $time, name, expV, actV);
    endtask

    task automatic checkWb(input WbResult_t expWb, input WbResult_t actWb);
        checkCount++;
        if (actWb.valid !== expWb.valid) begin
            reportMismatch("wbResult.valid", 32'(expWb.valid), 32'(actWb.valid));
        end else if (expWb.valid) begin
            if (actWb.destReg !== expWb.destReg) begin
                reportMismatch("wbResult.destReg", 32'(expWb.destReg), 32'(actWb.destReg));
            end
            if (actWb.data !== expWb.data) begin
                reportMismatch("wbResult.data", expWb.data, actWb.data);
            end
        end
    endtask

    task automatic checkExc(input MemExc_t expExc, input MemExc_t actExc);
        checkCount++;
        if (actExc.valid !== expExc.valid) begin
            reportMismatch("memExc.valid", 32'(expExc.valid), 32'(actExc.valid));
        end else if (expExc.valid) begin
            if (actExc.isStore !== expExc.isStore) begin
                reportMismatch("memExc.isStore", 32'(expExc.isStore), 32'(actExc.isStore));
            end
            if (actExc.badVAddr !== expExc.badVAddr) begin
                reportMismatch("memExc.badVAddr", expExc.badVAddr, actExc.badVAddr);
            end
        end
    endtask

    // Drives one request with stall low and checks what it gives one cycle later.
    task automatic access(input MemReq_t r);
        WbResult_t expWb;
        MemExc_t   expExc;
        logic      bad;
        bad    = misaligned(r);
        expWb  = '0;
        expExc = '0;
        if (bad) begin
            expExc.valid    = 1'b1;
            expExc.isStore  = r.isStore;
            expExc.badVAddr = r.addr;
        end else if (r.isLoad) begin
            expWb.valid   = 1'b1;
            expWb.destReg = r.destReg;
            expWb.data    = loadValue(r);
        end
        memReq = r;
        @(posedge clk);
        #1;
        memReq.valid = 1'b0;
        if (r.isStore && !bad) begin
            applyStore(r);
        end
        checkWb(expWb, wbResult);
        checkExc(expExc, memExc);
    endtask

    task automatic fillWords(input logic [31:0] base, input int count);
        logic [31:0] addr;
        for (int i = 0; i < count; i++) begin
            addr = base + 32'(4 * i);
            access(makeReq(opSw, addr, fillPattern(addr), 5'd0));
        end
    endtask

    task automatic swLwRoundTrip();
        logic [31:0] addr;
        fillWords(32'h100, 8);
        for (int i = 0; i < 8; i++) begin
            addr = 32'h100 + 32'(4 * i);
            access(makeReq(opSw, addr, ~fillPattern(addr), 5'd0));
            access(makeReq(opLw, addr, 32'h0, 5'(i + 1)));  // right after its store.
        end
        access(makeReq(opSw, 32'h520, 32'h0badf00d, 5'd0));  // aliases word 0x120.
        access(makeReq(opLw, 32'h120, 32'h0, 5'd31));
    endtask

    task automatic subwordAccess();
        fillWords(32'h200, 2);
        for (int k = 0; k < 4; k++) begin
            access(makeReq(opSb, 32'h200 + 32'(k), {24'h5a5a5a, 8'(8'h6d * (k + 1))}, 5'd0));
        end
        access(makeReq(opSh, 32'h204, 32'h12348001, 5'd0));
        access(makeReq(opSh, 32'h206, 32'h56787ffe, 5'd0));
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < 4; k++) begin
                for (int op = opLb; op <= opLhu; op++) begin
                    access(makeReq(op, 32'h200 + 32'(4 * w + k), 32'h0, 5'(4 * k + op)));
                end
            end
        end
    endtask

    task automatic leftRightAccess();
        logic [31:0] addr;
        fillWords(32'h300, 1);
        for (int k = 0; k < 4; k++) begin
            access(makeReq(opLwl, 32'h300 + 32'(k), 32'ha1b2c3d4, 5'(k + 1)));
            access(makeReq(opLwr, 32'h300 + 32'(k), 32'ha1b2c3d4, 5'(k + 5)));
        end
        for (int k = 0; k < 4; k++) begin
            addr = 32'h310 + 32'(4 * k);
            fillWords(addr, 1);
            access(makeReq(opSwl, addr + 32'(k), 32'h8192a3b4, 5'd0));
            access(makeReq(opLw, addr, 32'h0, 5'(k + 9)));
            addr = 32'h320 + 32'(4 * k);
            fillWords(addr, 1);
            access(makeReq(opSwr, addr + 32'(k), 32'h8192a3b4, 5'd0));
            access(makeReq(opLw, addr, 32'h0, 5'(k + 13)));
        end
    endtask

    task automatic misalignedAccess();
        fillWords(32'h380, 1);
        for (int k = 1; k < 4; k++) begin
            if (k != 2) begin
                access(makeReq(opLh, 32'h380 + 32'(k), 32'h0, 5'd3));
                access(makeReq(opSh, 32'h380 + 32'(k), 32'hdeadbeef, 5'd0));
            end
            access(makeReq(opLw, 32'h380 + 32'(k), 32'h0, 5'd4));
            access(makeReq(opSw, 32'h380 + 32'(k), 32'hdeadbeef, 5'd0));
        end
        access(makeReq(opLw, 32'h380, 32'h0, 5'd5));
    endtask

    task automatic holdUnderStall(input WbResult_t heldWb, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            #1;
            checkWb(heldWb, wbResult);
            checkExc('0, memExc);
        end
    endtask

    task automatic stallHold();
        MemReq_t   first;
        MemReq_t   pending;
        WbResult_t heldWb;
        fillWords(32'h3c0, 2);
        first  = makeReq(opLw, 32'h3c0, 32'h0, 5'd7);
        heldWb = '{valid: 1'b1, destReg: 5'd7, data: loadValue(first)};
        access(first);
        stall   = 1'b1;
        pending = makeReq(opLh, 32'h3c6, 32'h0, 5'd9);
        memReq  = pending;
        holdUnderStall(heldWb, 3);
        stall = 1'b0;
        access(pending);  // still on the port, taken once stall falls.
        heldWb  = '{valid: 1'b1, destReg: 5'd9, data: loadValue(pending)};
        stall   = 1'b1;
        pending = makeReq(opSw, 32'h3c4, 32'hc0ffee11, 5'd0);
        memReq  = pending;
        holdUnderStall(heldWb, 2);
        stall = 1'b0;
        access(pending);
        access(makeReq(opLw, 32'h3c4, 32'h0, 5'd10));
    endtask

    task automatic randomMix();
        int          op;
        logic [31:0] addr;
        fillWords(32'h40, 8);
        for (int n = 0; n < 200; n++) begin
            op   = int'($urandom_range(0, opSwr));
            addr = 32'h40 + $urandom_range(0, 31) + ($urandom_range(0, 3) << 10);
            access(makeReq(op, addr, $urandom(), 5'($urandom_range(0, 31))));
        end
    endtask

    initial begin
        void'($urandom(32'h3fbd2159));
        clk        = 1'b0;
        arstN      = 1'b0;
        stall      = 1'b0;
        memReq     = '0;
        errorCount = 0;
        checkCount = 0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkWb('0, wbResult);
        checkExc('0, memExc);
        swLwRoundTrip();
        subwordAccess();
        leftRightAccess();
        misalignedAccess();
        stallHold();
        randomMix();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* common/CachePkg.sv */
`include "mem_consts.svh"

package CachePkg;

    localparam int ramIndexBits = $clog2(`DCACHE_WORDS);

    typedef logic [ramIndexBits-1:0] RamIndex_t;

    typedef struct packed {
        logic [3:0]  byteEn;  // no write when all lanes are clear.
        RamIndex_t   index;
        logic [31:0] data;
    } RamWrite_t;

endpackage

/* common/CpuPkg.sv */
package CpuPkg;

    typedef struct packed {
        logic       sign;         // set for a sign-extending load.
        logic [1:0] size;
        logic [1:0] leftOrRight;
    } LoadType_t;

    typedef struct packed {
        logic [1:0] size;
        logic [1:0] leftOrRight;
    } StoreType_t;

    typedef struct packed {
        logic        valid;
        logic        isLoad;
        logic        isStore;
        logic [31:0] addr;
        logic [31:0] regRt;       // store data, or merge source for lwl and lwr.
        LoadType_t   loadType;
        StoreType_t  storeType;
        logic [4:0]  destReg;
    } MemReq_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  destReg;
        logic [31:0] data;
    } WbResult_t;

    typedef struct packed {
        logic        valid;
        logic        isStore;
        logic [31:0] badVAddr;
    } MemExc_t;

endpackage

/* common/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Load type codes are the sign bit followed by the size field.
`define LOADTYPE_LB  3'b100
`define LOADTYPE_LBU 3'b000
`define LOADTYPE_LH  3'b101
`define LOADTYPE_LHU 3'b001
`define LOADTYPE_LW  3'b010

// Store type codes are the size field alone.
`define STORETYPE_SB 2'b00
`define STORETYPE_SH 2'b01
`define STORETYPE_SW 2'b10

`define LR_NONE  2'b00  // plain aligned access.
`define LR_LEFT  2'b10  // lwl or swl.
`define LR_RIGHT 2'b01  // lwr or swr.

`define DCACHE_WORDS 256  // data ram depth in 32-bit words.

`endif

/* dcache/DcacheDataRam.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module DcacheDataRam (
    input  logic                clk,
    input  CachePkg::RamWrite_t wr,
    input  logic                rdEn,
    input  CachePkg::RamIndex_t rdIndex,
    output logic [31:0]         rdData
);
    logic [31:0] mem [`DCACHE_WORDS];

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wr.byteEn[b]) begin
                mem[wr.index][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
    end

    // the read word only moves on an enabled read, so it holds through a stall.
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdIndex];
        end
    end

    assert property (@(posedge clk) rdEn |-> !$isunknown(rdIndex))
        else $error("DcacheDataRam: unknown read index on an enabled read.");

    assert property (@(posedge clk) (|wr.byteEn) |-> !$isunknown(wr.index))
        else $error("DcacheDataRam: unknown write index on an enabled write.");

endmodule

/* hw/DcacheRdataSel.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module DcacheRdataSel (
    input  CpuPkg::LoadType_t loadType,
    input  logic [31:0]       cacheRdata,
    input  logic [31:0]       regRt,
    input  logic [1:0]        rdAddr,
    output logic [31:0]       rdData
);
    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [31:0] plainData;

    always_comb begin
        unique case (rdAddr)
            2'b00:   byteLane = cacheRdata[7:0];
            2'b01:   byteLane = cacheRdata[15:8];
            2'b10:   byteLane = cacheRdata[23:16];
            2'b11:   byteLane = cacheRdata[31:24];
            default: byteLane = 'x;
        endcase
    end

    assign halfLane = rdAddr[1] ? cacheRdata[31:16] : cacheRdata[15:0];

    always_comb begin
        unique case ({loadType.sign, loadType.size})
            `LOADTYPE_LB:  plainData = {{24{byteLane[7]}}, byteLane};
            `LOADTYPE_LBU: plainData = {24'b0, byteLane};
            `LOADTYPE_LH:  plainData = {{16{halfLane[15]}}, halfLane};
            `LOADTYPE_LHU: plainData = {16'b0, halfLane};
            `LOADTYPE_LW:  plainData = cacheRdata;
            default:       plainData = 'x;
        endcase
    end

    // lwl fills the result from the top down, lwr from the bottom up.
    always_comb begin
        unique case (loadType.leftOrRight)
            `LR_LEFT: begin
                unique case (rdAddr)
                    2'b00:   rdData = {cacheRdata[7:0], regRt[23:0]};
                    2'b01:   rdData = {cacheRdata[15:0], regRt[15:0]};
                    2'b10:   rdData = {cacheRdata[23:0], regRt[7:0]};
                    2'b11:   rdData = cacheRdata;
                    default: rdData = 'x;
                endcase
            end
            `LR_RIGHT: begin
                unique case (rdAddr)
                    2'b00:   rdData = cacheRdata;
                    2'b01:   rdData = {regRt[31:24], cacheRdata[31:8]};
                    2'b10:   rdData = {regRt[31:16], cacheRdata[31:16]};
                    2'b11:   rdData = {regRt[31:8], cacheRdata[31:24]};
                    default: rdData = 'x;
                endcase
            end
            default: rdData = plainData;
        endcase
    end

endmodule

/* hw/MemStage.sv */
`timescale 1ns/1ps

module MemStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              stall,
    input  CpuPkg::MemReq_t   memReq,
    output CpuPkg::WbResult_t wbResult,
    output CpuPkg::MemExc_t   memExc
);
    import CpuPkg::*;
    import CachePkg::*;

    RamWrite_t   alignWr;
    RamWrite_t   ramWr;
    logic        alignErr;
    logic        accept;
    logic        ramRdEn;
    logic [31:0] ramRdData;
    logic [31:0] loadData;

    logic        mem2Valid;
    logic        mem2Err;
    logic        mem2IsStore;
    LoadType_t   mem2LoadType;
    logic [31:0] mem2Addr;
    logic [31:0] mem2RegRt;
    logic [4:0]  mem2DestReg;

    StoreAlign StoreAlign_i (
        .req      (memReq),
        .ramWr    (alignWr),
        .alignErr (alignErr)
    );

    assign accept  = memReq.valid && !stall;
    assign ramRdEn = accept && memReq.isLoad && !alignErr;

    always_comb begin
        ramWr = alignWr;
        if (!accept || alignErr) begin
            ramWr.byteEn = 4'b0000;
        end
    end

    DcacheDataRam DcacheDataRam_i (
        .clk     (clk),
        .wr      (ramWr),
        .rdEn    (ramRdEn),
        .rdIndex (alignWr.index),
        .rdData  (ramRdData)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mem2Valid <= 1'b0;
            mem2Err   <= 1'b0;
        end else begin
            if (!stall) begin
                mem2Valid <= ramRdEn;  // a load result holds while stalled.
            end
            mem2Err <= accept && alignErr;  // the exception is a one-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem2IsStore  <= memReq.isStore;
            mem2LoadType <= memReq.loadType;
            mem2Addr     <= memReq.addr;
            mem2RegRt    <= memReq.regRt;
            mem2DestReg  <= memReq.destReg;
        end
    end

    DcacheRdataSel DcacheRdataSel_i (
        .loadType   (mem2LoadType),
        .cacheRdata (ramRdData),
        .regRt      (mem2RegRt),
        .rdAddr     (mem2Addr[1:0]),
        .rdData     (loadData)
    );

    always_comb begin
        wbResult.valid   = mem2Valid;
        wbResult.destReg = mem2DestReg;
        wbResult.data    = loadData;
        memExc.valid     = mem2Err;
        memExc.isStore   = mem2IsStore;
        memExc.badVAddr  = mem2Addr;
    end

    assert property (@(posedge clk) disable iff (!arstN) !(wbResult.valid && memExc.valid))
        else $error("MemStage: load result and exception reported together.");

endmodule

/* hw/StoreAlign.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module StoreAlign (
    input  CpuPkg::MemReq_t     req,
    output CachePkg::RamWrite_t ramWr,
    output logic                alignErr
);
    import CpuPkg::*;
    import CachePkg::*;

    LoadType_t  loadType;
    StoreType_t storeType;
    logic [1:0] offset;

    assign loadType  = req.loadType;
    assign storeType = req.storeType;
    assign offset    = req.addr[1:0];

    always_comb begin
        alignErr     = 1'b0;
        ramWr.byteEn = 4'b0000;
        ramWr.index  = RamIndex_t'(req.addr[31:2]);  // the word index wraps with the ram size.
        ramWr.data   = req.regRt;
        if (req.isLoad) begin
            if (loadType.leftOrRight == `LR_NONE) begin
                unique case ({loadType.sign, loadType.size})
                    `LOADTYPE_LH, `LOADTYPE_LHU: alignErr = offset[0];
                    `LOADTYPE_LW:                alignErr = |offset;
                    default:                     alignErr = 1'b0;
                endcase
            end
        end else if (req.isStore) begin
            unique case (storeType.leftOrRight)
                `LR_LEFT: begin
                    ramWr.byteEn = 4'b1111 >> (2'd3 - offset);
                    ramWr.data   = req.regRt >> {(2'd3 - offset), 3'b000};
                end
                `LR_RIGHT: begin
                    ramWr.byteEn = 4'b1111 << offset;
                    ramWr.data   = req.regRt << {offset, 3'b000};
                end
                default: begin
                    unique case (storeType.size)
                        `STORETYPE_SB: begin
                            ramWr.byteEn = 4'b0001 << offset;
                            ramWr.data   = {4{req.regRt[7:0]}};  // every lane carries the byte.
                        end
                        `STORETYPE_SH: begin
                            alignErr = offset[0];
                            unique case (offset)
                                2'b00:   ramWr.byteEn = 4'b0011;
                                2'b10:   ramWr.byteEn = 4'b1100;
                                default: ramWr.byteEn = 4'b0000;  // odd offsets write nothing.
                            endcase
                            ramWr.data = {2{req.regRt[15:0]}};
                        end
                        `STORETYPE_SW: begin
                            alignErr     = |offset;
                            ramWr.byteEn = (offset == 2'b00) ? 4'b1111 : 4'b0000;
                        end
                        default: ramWr.byteEn = 4'b0000;
                    endcase
                end
            endcase
        end
    end

    always_comb begin
        if (alignErr) begin
            assert (ramWr.byteEn == 4'b0000)
                else $error("StoreAlign: byte enables set on a misaligned access.");
        end
    end

endmodule
